// ==== hdl/fetch_pkg.sv ====
// Shared definitions for the instruction-fetch front end
// Imported by the sequencer, the buffer, the top level and the testbench
package fetch_pkg;

    // Word address, byte address without bits [1:0]
    typedef logic [29:0] fetch_addr_t;

    // One IFB entry, instruction word plus bus-error tag
    typedef struct packed {
        logic        err;   // Word came back with hresp high
        logic [31:0] instr; // Raw instruction word from hrdata
    } fetch_entry_t;

    // AHB3-Lite transfer types used by an instruction master
    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

    // Every fetch is a full 32-bit word
    localparam logic [2:0] HSIZE_WORD = 3'b010;

    // Byte address of the first fetch after reset
    localparam logic [31:0] RESET_VECTOR = 32'h0000_0100;

endpackage

// ==== hdl/fetch_buffer.sv ====
// Instruction fetch buffer between the fetch sequencer and decode
// Circular FIFO with occupancy count, free-entry output and a one-cycle flush
`timescale 1ns/100ps

module fetch_buffer
    import fetch_pkg::*;
#(
    parameter int IFB_DEPTH = 4
) (
    input  logic                           s_clk_i,
    input  logic                           rst_n_i,
    input  logic                           flush_i, // Drop all entries
    input  logic                           push_i,
    input  logic                           pop_i,
    input  fetch_entry_t                   entry_i,
    output fetch_entry_t                   entry_o, // Oldest entry
    output logic                           valid_o, // entry_o holds data
    output logic [$clog2(IFB_DEPTH+1)-1:0] free_o
);
    localparam int CNT_W = $clog2(IFB_DEPTH + 1);
    localparam int PTR_W = $clog2(IFB_DEPTH);
    localparam logic [CNT_W-1:0] DEPTH_C  = CNT_W'(IFB_DEPTH);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(IFB_DEPTH - 1);

    fetch_entry_t     mem_q [IFB_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push, do_pop;

    // Wraps also for depths that are not a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        next_ptr = (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
    endfunction

    assign do_push = push_i & ~flush_i & (count_q != DEPTH_C);
    assign do_pop  = pop_i & ~flush_i & (count_q != '0);

    assign entry_o = mem_q[rd_ptr_q];
    assign valid_o = count_q != '0;
    assign free_o  = DEPTH_C - count_q;

    always_ff @(posedge s_clk_i or negedge rst_n_i) begin
        if (~rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            // Push and pop together keep the count
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Storage
    always_ff @(posedge s_clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= entry_i;
        end
    end

endmodule

// ==== hdl/fetch_sequencer.sv ====
// Two-phase AHB fetch sequencer, FE0 is the address phase and FE1 the data phase
// Picks the next fetch address, drives the bus request and pushes returned words into the IFB
`timescale 1ns/100ps

module fetch_sequencer
    import fetch_pkg::*;
#(
    parameter int IFB_DEPTH = 4
) (
    input  logic                           s_clk_i,
    input  logic                           rst_n_i,
    input  logic                           flush_i,      // Redirect pulse from a later stage
    input  logic [31:0]                    flush_addr_i, // Redirect target, byte address
    input  logic [31:0]                    hrdata_i,
    input  logic                           hready_i,
    input  logic                           hresp_i,
    input  logic [$clog2(IFB_DEPTH+1)-1:0] ifb_free_i,   // Free IFB entries
    output logic [31:0]                    haddr_o,
    output logic [1:0]                     htrans_o,
    output logic [2:0]                     hsize_o,
    output logic                           hwrite_o,
    output logic [2:0]                     hburst_o,
    output logic [3:0]                     hprot_o,
    output logic                           hmastlock_o,
    output logic [31:0]                    hwdata_o,
    output logic                           ifb_push_o,
    output fetch_entry_t                   ifb_entry_o
);
    localparam int CNT_W = $clog2(IFB_DEPTH + 1);

    // FE0, the request on the address phase
    fetch_addr_t fe0_add_q, fe0_add_d;
    logic        fe0_busy_q, fe0_busy_d;
    // FE1, the request waiting for its data, or a parked redirect target
    fetch_addr_t fe1_add_q, fe1_add_d;
    logic        fe1_live_q, fe1_live_d;
    logic        fe1_park_q, fe1_park_d;

    logic [CNT_W-1:0] inflight;
    logic             issue_ok;
    fetch_addr_t      flush_add;

    assign flush_add = flush_addr_i[31:2]; // Word aligned target

    // Requests that will still need a slot, new one allowed only with room beyond them
    assign inflight = CNT_W'(fe0_busy_q) + CNT_W'(fe1_live_q);
    assign issue_ok = ifb_free_i > inflight;

    // Bus request
    assign haddr_o     = {fe0_add_q, 2'b00};
    assign htrans_o    = fe0_busy_q ? HTRANS_NONSEQ : HTRANS_IDLE;
    assign hsize_o     = HSIZE_WORD;
    assign hwrite_o    = 1'b0;    // Read only master
    assign hburst_o    = 3'b000;  // SINGLE
    assign hprot_o     = 4'b0000; // Opcode fetch, user, non-cacheable
    assign hmastlock_o = 1'b0;
    assign hwdata_o    = 32'h0;

    // Data phase done with a live request, error tag straight from hresp
    assign ifb_push_o        = fe1_live_q & hready_i & ~flush_i;
    assign ifb_entry_o.instr = hrdata_i;
    assign ifb_entry_o.err   = hresp_i;

    always_comb begin
        fe0_add_d  = fe0_add_q;
        fe0_busy_d = fe0_busy_q;
        fe1_add_d  = fe1_add_q;
        fe1_live_d = fe1_live_q;
        fe1_park_d = fe1_park_q;
        if (~hready_i & fe0_busy_q) begin
            // Address phase stuck on the bus, FE0 must hold
            if (flush_i) begin
                // Park the target in FE1, the stuck data is dropped
                fe1_add_d  = flush_add;
                fe1_live_d = 1'b0;
                fe1_park_d = 1'b1;
            end
        end else if (flush_i) begin
            fe0_add_d  = flush_add;
            fe0_busy_d = 1'b1; // IFB is emptied on this edge
            fe1_live_d = 1'b0; // Kill whatever is in the data phase
            fe1_park_d = 1'b0;
        end else if (hready_i & fe1_park_q) begin
            // Bus released, issue the parked redirect
            fe0_add_d  = fe1_add_q;
            fe0_busy_d = 1'b1;
            fe1_live_d = 1'b0; // Old FE0 request is stale
            fe1_park_d = 1'b0;
        end else if (hready_i) begin
            // Normal step, FE0 moves into FE1
            fe1_add_d  = fe0_add_q;
            fe1_live_d = fe0_busy_q;
            if (fe0_busy_q) begin
                fe0_add_d = fe0_add_q + 30'd1; // Next sequential word
            end
            fe0_busy_d = issue_ok;
        end else begin
            // FE1 still waiting but FE0 is free to start a request
            fe0_busy_d = issue_ok;
        end
    end

    always_ff @(posedge s_clk_i or negedge rst_n_i) begin
        if (~rst_n_i) begin
            fe0_add_q  <= RESET_VECTOR[31:2];
            fe0_busy_q <= 1'b0; // First request one cycle after reset release
            fe1_live_q <= 1'b0;
            fe1_park_q <= 1'b0;
        end else begin
            fe0_add_q  <= fe0_add_d;
            fe0_busy_q <= fe0_busy_d;
            fe1_live_q <= fe1_live_d;
            fe1_park_q <= fe1_park_d;
        end
    end

    // FE1 address only matters while live or parked
    always_ff @(posedge s_clk_i) begin
        fe1_add_q <= fe1_add_d;
    end

endmodule

// ==== hdl/fetch_top.sv ====
// Instruction-fetch front end top level
// Connects the AHB fetch sequencer and the IFB to the bus, redirect and decode ports
`timescale 1ns/100ps

module fetch_top
    import fetch_pkg::*;
#(
    parameter int IFB_DEPTH = 4
) (
    input  logic        s_clk_i,
    input  logic        rst_n_i,
    // AHB3-Lite master
    input  logic [31:0] hrdata_i,
    input  logic        hready_i,
    input  logic        hresp_i,
    output logic [31:0] haddr_o,
    output logic [1:0]  htrans_o,
    output logic [2:0]  hsize_o,
    output logic        hwrite_o,
    output logic [2:0]  hburst_o,
    output logic [3:0]  hprot_o,
    output logic        hmastlock_o,
    output logic [31:0] hwdata_o,
    // Redirect from a later stage
    input  logic        flush_i,
    input  logic [31:0] flush_addr_i,
    // Decode side
    input  logic        stall_i,
    output logic [31:0] instr_o,
    output logic        bus_err_o,
    output logic        instr_valid_o
);
    localparam int CNT_W = $clog2(IFB_DEPTH + 1);

    logic             ifb_push, ifb_pop;
    fetch_entry_t     ifb_entry, ifb_out;
    logic [CNT_W-1:0] ifb_free;

    assign ifb_pop   = instr_valid_o & ~stall_i; // Decode takes the head entry
    assign instr_o   = ifb_out.instr;
    assign bus_err_o = ifb_out.err;

    fetch_sequencer #(.IFB_DEPTH(IFB_DEPTH)) fetch_sequencer_i (
        .s_clk_i(s_clk_i), .rst_n_i(rst_n_i),
        .flush_i(flush_i), .flush_addr_i(flush_addr_i),
        .hrdata_i(hrdata_i), .hready_i(hready_i), .hresp_i(hresp_i),
        .ifb_free_i(ifb_free),
        .haddr_o(haddr_o), .htrans_o(htrans_o), .hsize_o(hsize_o),
        .hwrite_o(hwrite_o), .hburst_o(hburst_o), .hprot_o(hprot_o),
        .hmastlock_o(hmastlock_o), .hwdata_o(hwdata_o),
        .ifb_push_o(ifb_push), .ifb_entry_o(ifb_entry)
    );

    fetch_buffer #(.IFB_DEPTH(IFB_DEPTH)) fetch_buffer_i (
        .s_clk_i(s_clk_i), .rst_n_i(rst_n_i),
        .flush_i(flush_i), // Emptied on the redirect edge
        .push_i(ifb_push), .pop_i(ifb_pop),
        .entry_i(ifb_entry), .entry_o(ifb_out),
        .valid_o(instr_valid_o), .free_o(ifb_free)
    );

endmodule

// ==== verification/fetch_tb.sv ====
// Testbench for the instruction-fetch front end
// Runs the records of the trace file against an AHB memory model and a stalling decode stage
// Each record resets the DUT, then checks order, data, error tags and the bus behavior
`timescale 1ns/100ps

module fetch_tb
    import fetch_pkg::*;
();
    localparam int MAX_TESTS = 16;

    logic        s_clk, rst_n;
    logic [31:0] hrdata, haddr, hwdata, flush_addr, instr;
    logic        hready, hresp, flush, stall, bus_err, instr_valid;
    logic        hwrite, hmastlock;
    logic [1:0]  htrans;
    logic [2:0]  hsize, hburst;
    logic [3:0]  hprot;

    // Trace records
    string       names        [MAX_TESTS];
    logic [31:0] t_flush_addr [MAX_TESTS];
    int          t_flush_cyc  [MAX_TESTS]; // Cycle after reset release
    logic [31:0] t_wait       [MAX_TESTS]; // hready low when all mask bits hit
    logic [31:0] t_stall      [MAX_TESTS]; // Stall start when all mask bits hit
    logic [31:0] t_err_lo     [MAX_TESTS];
    logic [31:0] t_err_hi     [MAX_TESTS];
    int          t_words      [MAX_TESTS]; // Words after start or redirect point
    logic [31:0] t_first      [MAX_TESTS];
    int          ntests;

    int          errors, checks, test_errs, cycles, cycle_limit;
    logic [31:0] rnd;

    fetch_top fetch_top_i (
        .s_clk_i(s_clk), .rst_n_i(rst_n),
        .hrdata_i(hrdata), .hready_i(hready), .hresp_i(hresp),
        .haddr_o(haddr), .htrans_o(htrans), .hsize_o(hsize), .hwrite_o(hwrite),
        .hburst_o(hburst), .hprot_o(hprot), .hmastlock_o(hmastlock), .hwdata_o(hwdata),
        .flush_i(flush), .flush_addr_i(flush_addr),
        .stall_i(stall), .instr_o(instr), .bus_err_o(bus_err), .instr_valid_o(instr_valid)
    );

    initial begin
        s_clk = 1'b0;
        forever #10 s_clk = ~s_clk; // 20 ns period
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic in_range(input logic [31:0] a, input logic [31:0] lo,
                                      input logic [31:0] hi);
        return (a >= lo) && (a <= hi);
    endfunction

    task automatic check_value(input string test, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            test_errs++;
            $display("MISMATCH %s %s expected %h actual %h", test, what, exp, act);
        end
    endtask

    task automatic read_trace();
        int    fd, r, sp;
        string line, rest;
        ntests = 0;
        fd = $fopen("verification/fetch_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file verification/fetch_trace.txt");
            errors++;
            return;
        end
        while (!$feof(fd) && ntests < MAX_TESTS) begin
            r = $fgets(line, fd);
            if (r == 0 || line.len() < 2 || line[0] == "#") continue; // Blank or comment
            sp = 0;
            while (sp < line.len() && line[sp] != " ") sp++;
            names[ntests] = line.substr(0, sp - 1);
            rest = line.substr(sp + 1, line.len() - 1);
            r = $sscanf(rest, "%h %d %h %h %h %h %d %h", t_flush_addr[ntests],
                        t_flush_cyc[ntests], t_wait[ntests], t_stall[ntests],
                        t_err_lo[ntests], t_err_hi[ntests], t_words[ntests], t_first[ntests]);
            if (r != 8) begin
                $display("Trace record %s has %0d fields instead of 8", names[ntests], r);
                errors++;
            end else begin
                ntests++;
            end
        end
        $fclose(fd);
    endtask

    // One record resets the DUT, then drives the bus and decode side and checks at negedge
    task automatic run_test(input int t);
        logic [31:0] exp_addr, last_haddr, dp_addr, dp_addr_n;
        logic        dp_valid, dp_valid_n, flushed, first_pending;
        logic        was_stuck, redirect_wait, check_target, done;
        int          cyc, count, stall_left, stall_run, long_stalls, words_seen;
        exp_addr = RESET_VECTOR;
        last_haddr = '0;
        dp_addr = '0;
        dp_addr_n = '0;
        dp_valid = 1'b0;
        dp_valid_n = 1'b0;
        flushed = 1'b0;
        first_pending = t_flush_addr[t] == 0; // Redirect tests check the first word later
        was_stuck = 1'b0;
        redirect_wait = 1'b0;
        check_target = 1'b0;
        done = 1'b0;
        cyc = 0;
        count = 0;
        stall_left = 0;
        stall_run = 0;
        long_stalls = 0;
        words_seen = 0;
        test_errs = 0;
        @(posedge s_clk);
        #2;
        rst_n = 1'b0;
        flush = 1'b0;
        flush_addr = t_flush_addr[t];
        stall = 1'b0;
        hready = 1'b1;
        hresp = 1'b0;
        hrdata = '0;
        repeat (2) @(posedge s_clk);
        #2 rst_n = 1'b1;
        while (!done) begin
            @(posedge s_clk);
            #2;
            dp_valid = dp_valid_n; // Data phase accepted on this edge
            dp_addr  = dp_addr_n;
            rnd = xorshift32(rnd);
            hready = !(dp_valid && t_wait[t] != 0 && (rnd & t_wait[t]) == t_wait[t]);
            rnd = xorshift32(rnd);
            if (stall_left > 0) begin
                stall = 1'b1;
                stall_left--;
            end else if (t_stall[t] != 0 && (rnd & t_stall[t]) == t_stall[t]) begin
                stall = 1'b1;
                stall_left = int'((rnd >> 8) & 32'hf); // Stall of 1 to 16 cycles
            end else begin
                stall = 1'b0;
            end
            flush = (t_flush_addr[t] != 0) && (cyc == t_flush_cyc[t]);
            if (flush && dp_valid && t_wait[t] != 0) hready = 1'b0; // Catch FE0 stuck
            hrdata = dp_valid ? (dp_addr ^ 32'h5a5a_0000) : 32'h0;
            hresp  = dp_valid && in_range(dp_addr, t_err_lo[t], t_err_hi[t]);
            @(negedge s_clk);
            if (was_stuck) begin // Address phase must hold through wait states
                check_value(names[t], "held haddr", last_haddr, haddr);
                check_value(names[t], "held htrans", {30'b0, HTRANS_NONSEQ}, {30'b0, htrans});
            end
            if (htrans == HTRANS_NONSEQ) begin // Single word read, opcode fetch, no lock
                check_value(names[t], "hsize", {29'b0, HSIZE_WORD}, {29'b0, hsize});
                check_value(names[t], "hwrite", 32'd0, {31'b0, hwrite});
                check_value(names[t], "hburst", 32'd0, {29'b0, hburst});
                check_value(names[t], "hprot", 32'd0, {28'b0, hprot});
                check_value(names[t], "hmastlock", 32'd0, {31'b0, hmastlock});
                check_value(names[t], "hwdata", 32'd0, hwdata);
            end
            was_stuck  = !hready && htrans == HTRANS_NONSEQ;
            last_haddr = haddr;
            if (check_target) begin
                check_value(names[t], "redirect haddr", t_flush_addr[t], haddr);
                check_target = 1'b0;
            end
            if (redirect_wait && hready) begin // Parked target goes out next cycle
                check_target  = 1'b1;
                redirect_wait = 1'b0;
            end
            stall_run = stall ? stall_run + 1 : 0;
            if (stall_run == 10 && t_wait[t] == 0) begin // IFB is full so the bus must be idle
                check_value(names[t], "htrans in stall", {30'b0, HTRANS_IDLE}, {30'b0, htrans});
                long_stalls++;
            end
            if (flush) begin
                check_target  = !was_stuck;
                redirect_wait = was_stuck;
                exp_addr = t_flush_addr[t];
                count = 0;
                flushed = 1'b1;
                first_pending = 1'b1;
            end else if (instr_valid && !stall) begin
                if (first_pending) check_value(names[t], "first word", t_first[t], instr);
                first_pending = 1'b0;
                check_value(names[t], "instr", exp_addr ^ 32'h5a5a_0000, instr);
                check_value(names[t], "bus_err",
                            {31'b0, in_range(exp_addr, t_err_lo[t], t_err_hi[t])},
                            {31'b0, bus_err});
                exp_addr += 32'd4;
                count++;
                words_seen++;
            end
            if (hready) begin // Memory model sees the accepted address phase
                dp_valid_n = htrans == HTRANS_NONSEQ;
                dp_addr_n  = haddr;
            end
            cyc++;
            done = (t_flush_addr[t] == 0 || flushed) && count >= t_words[t];
        end
        flush = 1'b0;
        stall = 1'b0;
        if (t_stall[t] != 0 && t_wait[t] == 0 && long_stalls == 0) begin
            $display("%s: no stall lasted long enough to see the bus go idle", names[t]);
            errors++;
            test_errs++;
        end
        $display("%s: %0d words checked, %0d mismatches", names[t], words_seen, test_errs);
    endtask

    initial begin
        int total;
        rst_n = 1'b0;
        hrdata = '0;
        hready = 1'b1;
        hresp = 1'b0;
        flush = 1'b0;
        flush_addr = '0;
        stall = 1'b0;
        errors = 0;
        checks = 0;
        total = 0;
        rnd = 32'hd754_2182;
        read_trace();
        for (int i = 0; i < ntests; i++) total += t_words[i];
        cycle_limit = 4 * total + 200;
        for (int i = 0; i < ntests; i++) run_test(i);
        if (ntests == 0) begin
            $display("No test records were read from the trace file");
            errors++;
        end
        $display("Tests: %0d, checks: %0d, errors: %0d", ntests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Watchdog over the whole run
    initial begin
        cycles = 0;
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge s_clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the expected words did not all arrive", cycles);
        $display("Something failed");
        $finish;
    end

endmodule

// ==== verification/fetch_trace.txt ====
# One fetch test per line, hex except flush_cycle and words which are decimal
# name flush_addr flush_cycle wait_mask stall_mask err_lo err_hi words first_word
seq_basic       00000000  0 00000000 00000000 00000000 00000000 40 5a5a0100
wait_states     00000000  0 00000001 00000000 00000000 00000000 48 5a5a0100
decode_stall    00000000  0 00000000 00000003 00000000 00000000 48 5a5a0100
redirect_ready  00002000 12 00000000 00000000 00000000 00000000 24 5a5a2000
redirect_stuck  00003400 15 00000003 00000000 00000000 00000000 24 5a5a3400
bus_error       00000000  0 00000000 00000000 00000110 0000011c 32 5a5a0100
error_waits     00000000  0 00000003 00000000 00000120 0000013c 32 5a5a0100
mixed_redirect  00004800 20 00000007 00000007 00004810 00004814 32 5a5a4800

// ==== flist.f ====
hdl/fetch_pkg.sv
hdl/fetch_buffer.sv
hdl/fetch_sequencer.sv
hdl/fetch_top.sv
verification/fetch_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FLIST      := flist.f
TB_TOP     := fetch_tb
RTL_TOP    := fetch_top
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -Wno-fatal
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Everything OK

.PHONY: all lint sim clean

all: sim

# Lint the RTL from its top level
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

# Build and run the testbench, then look for the pass line in the log
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
